// ==== dotp_accel.f ====
rtl/dotp_pkg.sv
rtl/dotp_wb_regs.sv
rtl/dotp_lane.sv
rtl/dotp_collect.sv
rtl/dotp_top.sv
tests/dotp_tb.sv

// ==== rtl/dotp_collect.sv ====
/*
 * Result collector
 * Captures every lane result when the lanes retire and holds
 * them for bus readback until the next job finishes
 */
`default_nettype none

module dotp_collect #(
   parameter int LANES = 4,
   parameter int WIDTH = 16
) (
   input  logic                   clk,
   input  logic                   rst,
   input  logic [LANES*WIDTH-1:0] lane_res,
   input  logic [LANES-1:0]       lane_valid,
   output logic [LANES*WIDTH-1:0] results,
   output logic                   retire
);

   // ==========================================================================
   // Retire and capture
   // ==========================================================================

   // All lanes run in lockstep, lane 0 speaks for them
   assign retire = lane_valid[0];

   // Holding registers, one word per lane
   for (genvar k = 0; k < LANES; k++) begin : g_hold
      always_ff @(posedge clk or posedge rst) begin
         if (rst) begin
            results[k*WIDTH +: WIDTH] <= '0;
         end else if (retire) begin
            // Readable from the cycle after retire
            results[k*WIDTH +: WIDTH] <= lane_res[k*WIDTH +: WIDTH];
         end
      end
   end

   // Lanes share one issue, so valids never split
   a_valid_agree: assert property (@(posedge clk) disable iff (rst)
      (lane_valid == '0) || (lane_valid == '1));

endmodule

`default_nettype wire

// ==== rtl/dotp_lane.sv ====
/*
 * One dot-product lane
 * Four pipelined stages sum the products of adjacent operand pairs,
 * truncated to WIDTH, with a matching valid delay line
 */
`default_nettype none

module dotp_lane #(
   parameter int WIDTH = 16
) (
   input  logic                             clk,
   input  logic                             rst,
   input  logic                             issue,
   input  logic [dotp_pkg::N_OPS*WIDTH-1:0] ops,
   output logic [WIDTH-1:0]                 lane_res,
   output logic                             lane_valid
);
   import dotp_pkg::*;

   // Pairs multiplied per lane
   localparam int N_PROD = N_OPS / 2;

   logic [WIDTH-1:0]                  in_r   [N_OPS];
   logic [WIDTH-1:0]                  prod_r [N_PROD];
   logic [WIDTH-1:0]                  add_r  [N_PROD/2];
   logic [WIDTH-1:0]                  sum_r;
   logic [LANE_LATENCY-1:0]           vld_sr;
   logic [$clog2(LANE_LATENCY+1)-1:0] age;

   // ==========================================================================
   // Datapath, overflow dropped at every stage
   // ==========================================================================

   always_ff @(posedge clk) begin
      // Stage 1 input capture
      for (int i = 0; i < N_OPS; i++) begin
         in_r[i] <= ops[i*WIDTH +: WIDTH];
      end
      // Stage 2 pair products 0*1, 2*3, 4*5, 6*7
      for (int i = 0; i < N_PROD; i++) begin
         prod_r[i] <= in_r[2*i] * in_r[2*i+1];
      end
      // Stage 3 first adder level
      for (int i = 0; i < N_PROD/2; i++) begin
         add_r[i] <= prod_r[2*i] + prod_r[2*i+1];
      end
      // Stage 4 final sum
      sum_r <= add_r[0] + add_r[1];
   end

   assign lane_res = sum_r;

   // Valid follows issue through the same number of stages
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         vld_sr <= '0;
      end else begin
         vld_sr <= {vld_sr[LANE_LATENCY-2:0], issue};
      end
   end

   assign lane_valid = vld_sr[LANE_LATENCY-1];

   // Cycles since reset, saturates once the pipe is primed
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         age <= '0;
      end else if (age != LANE_LATENCY) begin
         age <= age + 1'b1;
      end
   end

   a_lane_lat: assert property (@(posedge clk) disable iff (rst)
      (age == LANE_LATENCY) |-> lane_valid == $past(issue, LANE_LATENCY));

endmodule

`default_nettype wire

// ==== rtl/dotp_pkg.sv ====
/*
 * Dot-product accelerator shared definitions
 * Bus word types, default sizes and the register address map
 */
`default_nettype none

package dotp_pkg;

   // ==========================================================================
   // Default sizes
   // ==========================================================================

   // Operand and result width
   localparam int DATA_W = 16;
   // Lanes built by default, 16 at most so operands fit below CTRL_ADR
   localparam int N_LANES = 4;
   // Operands per lane, fixed by the adder tree shape
   localparam int N_OPS = 8;
   // Issue to retire, one cycle per pipeline register
   localparam int LANE_LATENCY = 4;

   // Wishbone word and word address
   typedef logic [31:0] wb_data_t;
   typedef logic [7:0]  wb_adr_t;

   // ==========================================================================
   // Address map
   // ==========================================================================

   // Operand i of lane k at OPS_BASE + k*8 + i
   localparam wb_adr_t OPS_BASE = 8'h00;
   // Write bit 0 starts, read bit 0 busy and bit 1 done
   localparam wb_adr_t CTRL_ADR = 8'h80;
   // Result of lane k at RES_BASE + k
   localparam wb_adr_t RES_BASE = 8'h90;

endpackage

`default_nettype wire

// ==== rtl/dotp_top.sv ====
/*
 * Dot-product accelerator top level
 * Wishbone register block, generated lanes and result collector
 */
`default_nettype none

module dotp_top #(
   parameter int LANES = dotp_pkg::N_LANES,
   parameter int WIDTH = dotp_pkg::DATA_W
) (
   input  logic               clk,
   input  logic               rst,
   input  logic               cyc,
   input  logic               stb,
   input  logic               we,
   input  dotp_pkg::wb_adr_t  adr,
   input  dotp_pkg::wb_data_t dat_w,
   output logic               ack,
   output dotp_pkg::wb_data_t dat_r
);
   import dotp_pkg::*;

   // Register block to lanes
   logic                         issue;
   logic [N_OPS*LANES*WIDTH-1:0] ops;
   // Lanes to collector
   logic [LANES*WIDTH-1:0]       lane_res;
   logic [LANES-1:0]             lane_valid;
   // Collector back to register block
   logic [LANES*WIDTH-1:0]       results;
   logic                         retire;

   // ==========================================================================
   // Bus slave and sequencer
   // ==========================================================================

   dotp_wb_regs #(.LANES(LANES), .WIDTH(WIDTH)) u_regs (
      .clk(clk), .rst(rst), .cyc(cyc), .stb(stb), .we(we),
      .adr(adr), .dat_w(dat_w), .ack(ack), .dat_r(dat_r),
      .issue(issue), .ops(ops), .retire(retire), .results(results)
   );

   // One lane per operand group, all fed the same issue
   for (genvar k = 0; k < LANES; k++) begin : g_lane
      dotp_lane #(.WIDTH(WIDTH)) u_lane (
         .clk(clk), .rst(rst), .issue(issue),
         .ops(ops[k*N_OPS*WIDTH +: N_OPS*WIDTH]),
         .lane_res(lane_res[k*WIDTH +: WIDTH]),
         .lane_valid(lane_valid[k])
      );
   end

   dotp_collect #(.LANES(LANES), .WIDTH(WIDTH)) u_collect (
      .clk(clk), .rst(rst), .lane_res(lane_res), .lane_valid(lane_valid),
      .results(results), .retire(retire)
   );

endmodule

`default_nettype wire

// ==== rtl/dotp_wb_regs.sv ====
/*
 * Wishbone classic slave for the dot-product accelerator
 * Holds the operand bank, runs the start and status sequencer
 * and returns operands, status or results on reads
 */
`default_nettype none

module dotp_wb_regs #(
   parameter int LANES = 4,
   parameter int WIDTH = 16
) (
   input  logic                                   clk,
   input  logic                                   rst,
   input  logic                                   cyc,
   input  logic                                   stb,
   input  logic                                   we,
   input  dotp_pkg::wb_adr_t                      adr,
   input  dotp_pkg::wb_data_t                     dat_w,
   output logic                                   ack,
   output dotp_pkg::wb_data_t                     dat_r,
   output logic                                   issue,
   output logic [dotp_pkg::N_OPS*LANES*WIDTH-1:0] ops,
   input  logic                                   retire,
   input  logic [LANES*WIDTH-1:0]                 results
);
   import dotp_pkg::*;

   // Operand words across all lanes
   localparam int N_WORDS = LANES * N_OPS;

   // Sequencer states, local to this block
   typedef enum logic [1:0] {
      ST_IDLE,
      ST_BUSY,
      ST_DONE
   } seq_state_t;

   seq_state_t       state;
   logic [WIDTH-1:0] bank [N_WORDS];
   logic             acc_new;
   logic             start_req;
   int               ops_idx;
   int               res_idx;
   wb_data_t         rd_word;

   // ==========================================================================
   // Bus handshake and decode
   // ==========================================================================

   // First cycle of an access, ack not yet given
   assign acc_new = cyc && stb && !ack;

   // Offsets into the operand and result windows
   assign ops_idx = int'(adr) - int'(OPS_BASE);
   assign res_idx = int'(adr) - int'(RES_BASE);

   // Single-cycle registered ack, every address answers
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         ack <= 1'b0;
      end else begin
         ack <= acc_new;
      end
   end

   // Operand bank, whole word replaced on each write
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         for (int i = 0; i < N_WORDS; i++) begin
            bank[i] <= '0;
         end
      end else if (acc_new && we && ops_idx >= 0 && ops_idx < N_WORDS) begin
         bank[ops_idx] <= dat_w[WIDTH-1:0];
      end
   end

   // Flatten the bank, lane k owns words k*8 to k*8+7
   for (genvar w = 0; w < N_WORDS; w++) begin : g_ops
      assign ops[w*WIDTH +: WIDTH] = bank[w];
   end

   // ==========================================================================
   // Start and status sequencer
   // ==========================================================================

   // Start write seen, acted on in the ack cycle
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         start_req <= 1'b0;
      end else begin
         start_req <= acc_new && we && (adr == CTRL_ADR) && dat_w[0];
      end
   end

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         state <= ST_IDLE;
         issue <= 1'b0;
      end else begin
         issue <= 1'b0;
         case (state)
            // New start also clears done
            ST_IDLE, ST_DONE: begin
               if (start_req) begin
                  state <= ST_BUSY;
                  issue <= 1'b1;
               end
            end
            // Starts are dropped here, wait for the collector
            ST_BUSY: begin
               if (retire) begin
                  state <= ST_DONE;
               end
            end
            default: state <= ST_IDLE;
         endcase
      end
   end

   // ==========================================================================
   // Read multiplexer
   // ==========================================================================

   always_comb begin
      rd_word = '0;
      if (ops_idx >= 0 && ops_idx < N_WORDS) begin
         rd_word[WIDTH-1:0] = bank[ops_idx];
      end else if (adr == CTRL_ADR) begin
         rd_word[0] = (state == ST_BUSY);
         rd_word[1] = (state == ST_DONE);
      end else if (res_idx >= 0 && res_idx < LANES) begin
         rd_word[WIDTH-1:0] = results[res_idx*WIDTH +: WIDTH];
      end
   end

   // Read data lines up with ack
   always_ff @(posedge clk) begin
      if (acc_new) begin
         dat_r <= rd_word;
      end
   end

   // Ack only answers a master that held cyc and stb
   a_ack_req: assert property (@(posedge clk) disable iff (rst)
      $rose(ack) |-> $past(cyc && stb));

   // A job is never launched on top of a running one
   a_issue_idle: assert property (@(posedge clk) disable iff (rst)
      issue |-> $past(state) != ST_BUSY);

endmodule

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
# Build and run the dot-product accelerator testbench with Verilator
# A $fatal in the testbench gives a nonzero exit status
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
   --top-module dotp_tb \
   -f dotp_accel.f \
   -o dotp_sim

./obj_dir/dotp_sim

// ==== tests/dotp_tb.sv ====
/*
 * Testbench for the dot-product accelerator
 * Random operands over Wishbone, results checked against a model
 */
`default_nettype none

module dotp_tb;
   import dotp_pkg::*;

   // Bus waits and status polls give up after this many cycles
   localparam int ACK_LIMIT  = 16;
   localparam int POLL_LIMIT = 40;
   localparam int N_WORDS    = N_LANES * N_OPS;

   logic              clk = 1'b0;
   logic              rst;
   logic              cyc;
   logic              stb;
   logic              we;
   wb_adr_t           adr;
   wb_data_t          dat_w;
   logic              ack;
   wb_data_t          dat_r;
   logic [31:0]       lfsr;
   logic [DATA_W-1:0] shadow [N_WORDS];
   logic [DATA_W-1:0] expect_res [N_LANES];

   dotp_top UUT (
      .clk(clk), .rst(rst), .cyc(cyc), .stb(stb), .we(we),
      .adr(adr), .dat_w(dat_w), .ack(ack), .dat_r(dat_r)
   );

   always #50 clk = ~clk;

   // ==========================================================================
   // Random source and reference model
   // ==========================================================================

   // Galois LFSR, taps for x^32 + x^22 + x^2 + x + 1
   function automatic logic lfsr_bit();
      logic out;
      out = lfsr[0];
      lfsr = {1'b0, lfsr[31:1]};
      if (out) lfsr = lfsr ^ 32'h8020_0003;
      return out;
   endfunction

   function automatic wb_data_t rand_value(input int nbits);
      wb_data_t v;
      v = '0;
      for (int i = 0; i < nbits; i++) v = {v[30:0], lfsr_bit()};
      return v;
   endfunction

   // Pair products 0*1 .. 6*7 summed, everything kept mod 2^DATA_W
   task automatic snapshot_model();
      logic [DATA_W-1:0] acc;
      logic [DATA_W-1:0] prod;
      for (int k = 0; k < N_LANES; k++) begin
         acc = '0;
         for (int p = 0; p < N_OPS / 2; p++) begin
            prod = shadow[k*N_OPS + 2*p] * shadow[k*N_OPS + 2*p + 1];
            acc  = acc + prod;
         end
         expect_res[k] = acc;
      end
   endtask

   // ==========================================================================
   // Checks
   // ==========================================================================

   task automatic stop_run(input string why);
      $display("Result: FAILED");
      $fatal(1, "%s", why);
   endtask

   task automatic check_data(input string name, input wb_data_t got, input wb_data_t exp);
      if (got !== exp) begin
         $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
         stop_run("data word differs from model");
      end
   endtask

   task automatic check_status(input string name, input wb_data_t got, input wb_data_t exp);
      if (got !== exp) begin
         $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
         stop_run("status word differs from model");
      end
   endtask

   task automatic check_flag(input string name, input logic got, input logic exp);
      if (got !== exp) begin
         $display("mismatch at %0t: %s got %b expected %b", $time, name, got, exp);
         stop_run("bus flag differs from model");
      end
   endtask

   // ==========================================================================
   // Bus master, always entered and left one tick after a rising edge
   // ==========================================================================

   // Steps at least one edge, since ack of the last access may still be high
   task automatic wait_ack(input string what);
      int n;
      n = 0;
      do begin
         @(posedge clk);
         #1;
         n++;
         if (n > ACK_LIMIT) stop_run({"timeout waiting for ack of a bus ", what});
      end while (ack !== 1'b1);
   endtask

   task automatic bus_write(input wb_adr_t a, input wb_data_t d);
      cyc = 1'b1;
      stb = 1'b1;
      we = 1'b1;
      adr = a;
      dat_w = d;
      wait_ack("write");
      cyc = 1'b0;
      stb = 1'b0;
      we = 1'b0;
   endtask

   task automatic bus_read(input wb_adr_t a, output wb_data_t d);
      cyc = 1'b1;
      stb = 1'b1;
      we = 1'b0;
      adr = a;
      wait_ack("read");
      d = dat_r;
      cyc = 1'b0;
      stb = 1'b0;
   endtask

   task automatic write_operand(input int idx, input wb_data_t d);
      bus_write(wb_adr_t'(int'(OPS_BASE) + idx), d);
      shadow[idx] = d[DATA_W-1:0];
   endtask

   // Start, then the next status read must show busy with done cleared
   task automatic start_job();
      wb_data_t st;
      bus_write(CTRL_ADR, 32'h1);
      bus_read(CTRL_ADR, st);
      check_status("dat_r status after start", st, 32'h1);
   endtask

   task automatic wait_done();
      wb_data_t st;
      int n;
      n = 0;
      st = '0;
      while (st[1] !== 1'b1) begin
         if (n == POLL_LIMIT) stop_run("timeout polling status for done");
         bus_read(CTRL_ADR, st);
         n++;
      end
      check_status("dat_r status when done", st, 32'h2);
   endtask

   task automatic check_results();
      wb_data_t d;
      for (int k = 0; k < N_LANES; k++) begin
         bus_read(wb_adr_t'(int'(RES_BASE) + k), d);
         check_data($sformatf("dat_r result lane %0d", k), d, wb_data_t'(expect_res[k]));
      end
   endtask

   // ==========================================================================
   // Test sequence
   // ==========================================================================

   initial begin
      wb_data_t d;
      rst = 1'b1;
      cyc = 1'b0;
      stb = 1'b0;
      we = 1'b0;
      adr = '0;
      dat_w = '0;
      lfsr = 32'h5c76d521;
      for (int i = 0; i < N_WORDS; i++) shadow[i] = '0;
      repeat (3) @(posedge clk);
      #1;
      rst = 1'b0;

      // Quiet bus, cleared status and results
      for (int i = 0; i < 4; i++) begin
         @(posedge clk);
         #1;
         check_flag("ack", ack, 1'b0);
      end
      bus_read(CTRL_ADR, d);
      check_status("dat_r status after reset", d, '0);
      snapshot_model();
      check_results();

      // Full 32-bit words written, only the low DATA_W bits come back
      for (int i = 0; i < N_WORDS; i++) write_operand(i, rand_value(32));
      for (int i = 0; i < N_WORDS; i++) begin
         bus_read(wb_adr_t'(int'(OPS_BASE) + i), d);
         check_data($sformatf("dat_r operand %0d", i), d, wb_data_t'(shadow[i]));
      end

      // Lane 0 all ones overflows every product
      for (int i = 0; i < N_OPS; i++) write_operand(i, 32'hffff);
      snapshot_model();
      start_job();
      wait_done();
      check_results();

      // New operands for this job, so held results of the last one differ
      for (int i = 0; i < N_WORDS; i++) write_operand(i, rand_value(DATA_W));
      // Operand change lands after issue, start while busy is dropped
      snapshot_model();
      bus_write(CTRL_ADR, 32'h1);
      write_operand(0, wb_data_t'(shadow[0] ^ 16'h5a5a));
      bus_write(CTRL_ADR, 32'h1);
      wait_done();
      check_results();
      bus_read(CTRL_ADR, d);
      check_status("dat_r status after dropped start", d, 32'h2);

      // Back to back random jobs
      for (int j = 0; j < 20; j++) begin
         for (int i = 0; i < N_WORDS; i++) write_operand(i, rand_value(DATA_W));
         snapshot_model();
         start_job();
         wait_done();
         check_results();
      end

      // Holes in the map answer with zero
      bus_read(8'h81, d);
      check_data("dat_r unmapped 0x81", d, '0);
      bus_read(8'ha0, d);
      check_data("dat_r unmapped 0xa0", d, '0);

      $display("Result: PASSED");
      $finish;
   end

endmodule

`default_nettype wire
